/* rtl/eflash_drv_pkg.sv */
// shared types for the row driver; op codes PARALLEL and LOAD exist only so that they decode as idle
`default_nettype none

package eflash_drv_pkg;

    // array geometry
    localparam int unsigned NUM_ROWS        = 128;
    localparam int unsigned NUM_SECTORS     = 8;
    localparam int unsigned ROWS_PER_SECTOR = NUM_ROWS / NUM_SECTORS;
    localparam int unsigned BSEL_W          = 32;
    localparam int unsigned COL_GROUPS      = BSEL_W / NUM_SECTORS;

    // input buffer beat layout
    localparam int unsigned IN_ELEM_W       = 2;
    localparam int unsigned BEAT_W          = 32;
    localparam int unsigned ELEMS_PER_BEAT  = BEAT_W / IN_ELEM_W;

    typedef logic [$clog2(NUM_ROWS)-1:0]    row_addr_t;
    typedef logic [8:0]                     col_addr_t;
    typedef logic [$clog2(NUM_SECTORS)-1:0] sector_t;
    typedef logic [$clog2(COL_GROUPS)-1:0]  col_grp_t;
    typedef logic [3:0]                     phase_t;
    typedef logic [IN_ELEM_W-1:0]           in_elem_t;
    typedef logic [BEAT_W-1:0]              beat_data_t;
    typedef logic [1:0]                     rsel_t;

    // 000 and 100 are not defined and fall to idle as well
    typedef enum logic [2:0] {
        OP_ERASE    = 3'b001,
        OP_PROGRAM  = 3'b010,
        OP_READ     = 3'b011,
        OP_PARALLEL = 3'b101,
        OP_RBR      = 3'b110,
        OP_LOAD     = 3'b111
    } pim_op_e;

    typedef enum logic [1:0] {
        HV_ERASE   = 2'b00,
        HV_PROGRAM = 2'b01,
        HV_READ    = 2'b10
    } hv_mode_e;

    typedef struct packed {
        logic      en;
        pim_op_e   op;
        phase_t    phase;
        row_addr_t row;
        col_addr_t col;
    } pim_cmd_t;

    typedef struct packed {
        hv_mode_e            mode;
        logic [NUM_ROWS-1:0] wl_sel;
        logic [NUM_ROWS-1:0] vpass_en;
    } wl_ctrl_t;

    typedef struct packed {
        logic [NUM_SECTORS-1:0] duml;
        logic [NUM_SECTORS-1:0] csl;
        logic [BSEL_W-1:0]      bsel;
        logic [NUM_SECTORS-1:0] csel;
        logic                   adc_en;
        rsel_t                  rsel;
        logic                   capture;
    } bl_ctrl_t;

    // word lines parked: no row selected, every pass gate on
    localparam wl_ctrl_t WL_IDLE = '{mode: HV_ERASE, wl_sel: '0, vpass_en: '1};

    // reference used by single-row sensing
    localparam rsel_t RSEL_ROW = 2'b01;

endpackage

`default_nettype wire

/* rtl/wordline_decoder.sv */
// word-line controls registered one cycle after the command; any op other than erase/program/read/RBR parks the rows
`timescale 1ns/1ps
`default_nettype none

module wordline_decoder (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire eflash_drv_pkg::pim_cmd_t cmd_i,
    output eflash_drv_pkg::wl_ctrl_t      wl_o
);

    eflash_drv_pkg::wl_ctrl_t                  wl_d;
    logic [eflash_drv_pkg::NUM_ROWS-1:0]       row_oh;

    // single selected row
    assign row_oh = {{(eflash_drv_pkg::NUM_ROWS-1){1'b0}}, 1'b1} << cmd_i.row;

    always_comb begin
        wl_d = eflash_drv_pkg::WL_IDLE;
        if (cmd_i.en) begin
            case (cmd_i.op)
                eflash_drv_pkg::OP_ERASE: begin
                    // other rows stay passed so only the target sees erase bias
                    wl_d.mode     = eflash_drv_pkg::HV_ERASE;
                    wl_d.wl_sel   = row_oh;
                    wl_d.vpass_en = '1;
                end
                eflash_drv_pkg::OP_PROGRAM: begin
                    wl_d.mode     = eflash_drv_pkg::HV_PROGRAM;
                    wl_d.wl_sel   = row_oh;
                    wl_d.vpass_en = row_oh;
                end
                eflash_drv_pkg::OP_READ,
                eflash_drv_pkg::OP_RBR: begin
                    wl_d.mode     = eflash_drv_pkg::HV_READ;
                    wl_d.wl_sel   = row_oh;
                    wl_d.vpass_en = row_oh;
                end
                default: begin
                    wl_d = eflash_drv_pkg::WL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wl_o <= eflash_drv_pkg::WL_IDLE;
        end else begin
            wl_o <= wl_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/bitline_sequencer.sv */
// bit-line and sense controls registered one cycle after the command; read phases count down from 9, phases 0 and above 9 are quiet
`timescale 1ns/1ps
`default_nettype none

module bitline_sequencer (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire eflash_drv_pkg::pim_cmd_t cmd_i,
    output eflash_drv_pkg::bl_ctrl_t      bl_o
);

    eflash_drv_pkg::bl_ctrl_t                  bl_d;
    eflash_drv_pkg::sector_t                   sector;
    eflash_drv_pkg::col_grp_t                  col_grp;
    logic [eflash_drv_pkg::NUM_SECTORS-1:0]    sector_oh;
    logic [eflash_drv_pkg::COL_GROUPS-1:0]     grp_oh;
    logic [eflash_drv_pkg::BSEL_W-1:0]         bsel_grp;
    logic                                      is_rbr;

    // 16 rows per sector, column group is col mod 4
    assign sector  = eflash_drv_pkg::sector_t'(cmd_i.row / eflash_drv_pkg::ROWS_PER_SECTOR);
    assign col_grp = eflash_drv_pkg::col_grp_t'(cmd_i.col % eflash_drv_pkg::COL_GROUPS);

    assign sector_oh = {{(eflash_drv_pkg::NUM_SECTORS-1){1'b0}}, 1'b1} << sector;
    assign grp_oh    = {{(eflash_drv_pkg::COL_GROUPS-1){1'b0}}, 1'b1} << col_grp;

    // same column picked in every group of four
    assign bsel_grp = {(eflash_drv_pkg::BSEL_W / eflash_drv_pkg::COL_GROUPS){grp_oh}};

    assign is_rbr = (cmd_i.op == eflash_drv_pkg::OP_RBR);

    always_comb begin
        bl_d = '0;
        if (cmd_i.en) begin
            case (cmd_i.op)
                eflash_drv_pkg::OP_ERASE: begin
                    bl_d.bsel = '1;
                    bl_d.csel = sector_oh;
                end
                eflash_drv_pkg::OP_PROGRAM: begin
                    bl_d.bsel = bsel_grp;
                    bl_d.csl  = sector_oh;
                    bl_d.csel = sector_oh;
                end
                eflash_drv_pkg::OP_READ,
                eflash_drv_pkg::OP_RBR: begin
                    // reference held for the whole operation, like the word lines
                    bl_d.rsel = eflash_drv_pkg::RSEL_ROW;
                    case (cmd_i.phase)
                        4'd9, 4'd8, 4'd7, 4'd6: begin
                            // precharge through the dummy line
                            bl_d.duml = sector_oh;
                            bl_d.bsel = bsel_grp;
                        end
                        4'd5, 4'd4: begin
                            bl_d.bsel = bsel_grp;
                            // RBR keeps the dummy line on while inputs settle
                            if (is_rbr) begin
                                bl_d.duml = sector_oh;
                            end
                        end
                        4'd3: begin
                            bl_d.csel = sector_oh;
                        end
                        4'd2, 4'd1: begin
                            bl_d.csel    = sector_oh;
                            bl_d.adc_en  = 1'b1;
                            // sample on the last ADC cycle
                            bl_d.capture = (cmd_i.phase == 4'd1);
                        end
                        default: begin
                            bl_d.csel = '0;
                        end
                    endcase
                end
                default: begin
                    bl_d = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            bl_o <= '0;
        end else begin
            bl_o <= bl_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/input_row_buffer.sv */
// 2-bit input store written 16 entries per beat; BUF_BEATS up to 16, beats beyond it are dropped, read-out only under RBR
`timescale 1ns/1ps
`default_nettype none

module input_row_buffer #(
    parameter int unsigned BUF_BEATS = 2
) (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire logic                       load_valid_i,
    input  wire eflash_drv_pkg::phase_t     load_beat_i,
    input  wire eflash_drv_pkg::beat_data_t load_data_i,
    input  wire eflash_drv_pkg::pim_op_e    op_i,
    input  wire logic                       buf_read_i,
    output eflash_drv_pkg::in_elem_t [BUF_BEATS*eflash_drv_pkg::ELEMS_PER_BEAT-1:0] row_data_o
);

    localparam int unsigned EPB = eflash_drv_pkg::ELEMS_PER_BEAT;

    eflash_drv_pkg::in_elem_t [BUF_BEATS*EPB-1:0] mem_q;

    // entry i of a beat sits at bits 2i+1..2i, same as the packed layout
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_q <= '0;
        end else if (load_valid_i) begin
            for (int unsigned b = 0; b < BUF_BEATS; b++) begin
                if (load_beat_i == eflash_drv_pkg::phase_t'(b)) begin
                    mem_q[b*EPB +: EPB] <= load_data_i;
                end
            end
        end
    end

    assign row_data_o = (buf_read_i && op_i == eflash_drv_pkg::OP_RBR) ? mem_q : '0;

endmodule

`default_nettype wire

/* rtl/eflash_row_driver.sv */
// row driver top; no handshake, commands and loads are taken every cycle, decoder outputs lag by one clock
`timescale 1ns/1ps
`default_nettype none

module eflash_row_driver #(
    parameter int unsigned BUF_BEATS = 2
) (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,

    input  wire eflash_drv_pkg::pim_cmd_t   cmd_i,

    // input buffer load
    input  wire logic                       load_valid_i,
    input  wire eflash_drv_pkg::phase_t     load_beat_i,
    input  wire eflash_drv_pkg::beat_data_t load_data_i,
    input  wire logic                       buf_read_i,

    output eflash_drv_pkg::wl_ctrl_t        wl_o,
    output eflash_drv_pkg::bl_ctrl_t        bl_o,
    output eflash_drv_pkg::in_elem_t [BUF_BEATS*eflash_drv_pkg::ELEMS_PER_BEAT-1:0] row_data_o
);

    input_row_buffer #(
        .BUF_BEATS    (BUF_BEATS)
    ) input_row_buffer_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .load_valid_i (load_valid_i),
        .load_beat_i  (load_beat_i),
        .load_data_i  (load_data_i),
        .op_i         (cmd_i.op),
        .buf_read_i   (buf_read_i),
        .row_data_o   (row_data_o)
    );

    // word-line side of the decode
    wordline_decoder wordline_decoder_i (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .cmd_i  (cmd_i),
        .wl_o   (wl_o)
    );

    // bit-line and sense side
    bitline_sequencer bitline_sequencer_i (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .cmd_i  (cmd_i),
        .bl_o   (bl_o)
    );

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
// free-running testbench clock; reset is released on a falling edge after RESET_CYCLES periods
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int unsigned PERIOD_NS    = 8,
    parameter int unsigned RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        #(PERIOD_NS * RESET_CYCLES) rst_no = 1'b1;
    end

endmodule

`default_nettype wire

/* dv/eflash_row_driver_tb.sv */
// BUF_BEATS fixed at 2; each command is checked on the falling edge after the one it was driven on
`timescale 1ns/1ps
`default_nettype none

module eflash_row_driver_tb;

    localparam int unsigned BUF_BEATS   = 2;
    localparam int unsigned ROW_ELEMS   = BUF_BEATS * eflash_drv_pkg::ELEMS_PER_BEAT;
    localparam realtime     POLL_NS     = 0.1;
    localparam int unsigned EDGE_POLLS  = 200;
    localparam int unsigned RESET_POLLS = 1000;

    typedef eflash_drv_pkg::in_elem_t [ROW_ELEMS-1:0] row_data_t;

    typedef struct {
        eflash_drv_pkg::pim_cmd_t   cmd;
        logic                       buf_read;
        logic                       load_valid;
        eflash_drv_pkg::phase_t     load_beat;
        eflash_drv_pkg::beat_data_t load_data;
        logic                       check_rows;
        eflash_drv_pkg::wl_ctrl_t   exp_wl;
        eflash_drv_pkg::bl_ctrl_t   exp_bl;
        row_data_t                  exp_rows;
    } entry_t;

    logic                       clk;
    logic                       rst_n;
    eflash_drv_pkg::pim_cmd_t   cmd;
    logic                       load_valid;
    eflash_drv_pkg::phase_t     load_beat;
    eflash_drv_pkg::beat_data_t load_data;
    logic                       buf_read;
    eflash_drv_pkg::wl_ctrl_t   wl;
    eflash_drv_pkg::bl_ctrl_t   bl;
    row_data_t                  row_data;

    entry_t      stim_q[$];
    row_data_t   shadow;
    int unsigned n_errors;
    int unsigned n_checks;

    tb_clock_gen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (2)
    ) clock_gen_i (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    eflash_row_driver #(
        .BUF_BEATS    (BUF_BEATS)
    ) eflash_row_driver_i (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .cmd_i        (cmd),
        .load_valid_i (load_valid),
        .load_beat_i  (load_beat),
        .load_data_i  (load_data),
        .buf_read_i   (buf_read),
        .wl_o         (wl),
        .bl_o         (bl),
        .row_data_o   (row_data)
    );

    function automatic eflash_drv_pkg::wl_ctrl_t model_wl(input eflash_drv_pkg::pim_cmd_t c);
        eflash_drv_pkg::wl_ctrl_t w;
        logic [eflash_drv_pkg::NUM_ROWS-1:0] oh;
        oh = '0;
        oh[c.row] = 1'b1;
        // parked rows unless a known op is enabled
        w.mode = eflash_drv_pkg::HV_ERASE;
        w.wl_sel = '0;
        w.vpass_en = '1;
        if (c.en && c.op == eflash_drv_pkg::OP_ERASE) begin
            w.wl_sel = oh;
        end else if (c.en && c.op == eflash_drv_pkg::OP_PROGRAM) begin
            w.mode = eflash_drv_pkg::HV_PROGRAM;
            w.wl_sel = oh;
            w.vpass_en = oh;
        end else if (c.en && (c.op == eflash_drv_pkg::OP_READ ||
                              c.op == eflash_drv_pkg::OP_RBR)) begin
            w.mode = eflash_drv_pkg::HV_READ;
            w.wl_sel = oh;
            w.vpass_en = oh;
        end
        return w;
    endfunction

    function automatic eflash_drv_pkg::bl_ctrl_t model_bl(input eflash_drv_pkg::pim_cmd_t c);
        eflash_drv_pkg::bl_ctrl_t b;
        logic [eflash_drv_pkg::NUM_SECTORS-1:0] sec_oh;
        logic [eflash_drv_pkg::BSEL_W-1:0] grp_bsel;
        int idx;
        b = '0;
        sec_oh = '0;
        sec_oh[c.row / 16] = 1'b1;
        grp_bsel = '0;
        for (int k = 0; k < 8; k++) begin
            idx = 4 * k + int'(c.col[1:0]);
            grp_bsel[idx] = 1'b1;
        end
        if (c.en && c.op == eflash_drv_pkg::OP_ERASE) begin
            b.bsel = '1;
            b.csel = sec_oh;
        end else if (c.en && c.op == eflash_drv_pkg::OP_PROGRAM) begin
            b.bsel = grp_bsel;
            b.csl = sec_oh;
            b.csel = sec_oh;
        end else if (c.en && (c.op == eflash_drv_pkg::OP_READ ||
                              c.op == eflash_drv_pkg::OP_RBR)) begin
            b.rsel = 2'b01;
            if (c.phase >= 4'd6 && c.phase <= 4'd9) begin
                b.duml = sec_oh;
                b.bsel = grp_bsel;
            end else if (c.phase == 4'd5 || c.phase == 4'd4) begin
                b.bsel = grp_bsel;
                if (c.op == eflash_drv_pkg::OP_RBR) begin
                    b.duml = sec_oh;
                end
            end else if (c.phase == 4'd3) begin
                b.csel = sec_oh;
            end else if (c.phase == 4'd2 || c.phase == 4'd1) begin
                b.csel = sec_oh;
                b.adc_en = 1'b1;
                b.capture = (c.phase == 4'd1);
            end
        end
        return b;
    endfunction

    function automatic eflash_drv_pkg::pim_cmd_t make_cmd(input logic en,
            input eflash_drv_pkg::pim_op_e op, input eflash_drv_pkg::phase_t phase,
            input eflash_drv_pkg::row_addr_t row, input eflash_drv_pkg::col_addr_t col);
        eflash_drv_pkg::pim_cmd_t c;
        c.en = en;
        c.op = op;
        c.phase = phase;
        c.row = row;
        c.col = col;
        return c;
    endfunction

    function automatic eflash_drv_pkg::row_addr_t rand_row();
        return eflash_drv_pkg::row_addr_t'($urandom_range(eflash_drv_pkg::NUM_ROWS - 1));
    endfunction

    function automatic eflash_drv_pkg::col_addr_t rand_col();
        return eflash_drv_pkg::col_addr_t'($urandom);
    endfunction

    // expected values follow the buffer contents as the table is built
    task automatic push_entry(input entry_t e);
        if (e.load_valid && int'(e.load_beat) < int'(BUF_BEATS)) begin
            for (int i = 0; i < 16; i++) begin
                shadow[16 * int'(e.load_beat) + i] = e.load_data[2*i +: 2];
            end
        end
        e.exp_wl = model_wl(e.cmd);
        e.exp_bl = model_bl(e.cmd);
        e.exp_rows = (e.buf_read && e.cmd.op == eflash_drv_pkg::OP_RBR) ? shadow : '0;
        stim_q.push_back(e);
    endtask

    task automatic add_cmd(input eflash_drv_pkg::pim_cmd_t c, input logic rd, input logic chk);
        entry_t e;
        e.cmd = c;
        e.buf_read = rd;
        e.load_valid = 1'b0;
        e.load_beat = '0;
        e.load_data = '0;
        e.check_rows = chk;
        push_entry(e);
    endtask

    task automatic add_load(input eflash_drv_pkg::phase_t beat,
            input eflash_drv_pkg::beat_data_t data);
        entry_t e;
        e.cmd = make_cmd(1'b0, eflash_drv_pkg::pim_op_e'(3'b000), 4'd0, '0, '0);
        e.buf_read = 1'b1;
        e.load_valid = 1'b1;
        e.load_beat = beat;
        e.load_data = data;
        e.check_rows = 1'b1;
        push_entry(e);
    endtask

    task automatic build_table();
        eflash_drv_pkg::row_addr_t row;
        eflash_drv_pkg::col_addr_t col;
        eflash_drv_pkg::pim_op_e   idle_ops[4];
        for (int n = 0; n < 6; n++) begin
            add_cmd(make_cmd(1'b1, eflash_drv_pkg::OP_ERASE, 4'd0, rand_row(), rand_col()),
                    1'b0, 1'b0);
        end
        for (int n = 0; n < 6; n++) begin
            add_cmd(make_cmd(1'b1, eflash_drv_pkg::OP_PROGRAM, 4'd0, rand_row(), rand_col()),
                    1'b0, 1'b0);
        end
        add_load(4'd0, eflash_drv_pkg::beat_data_t'($urandom));
        add_load(4'd1, eflash_drv_pkg::beat_data_t'($urandom));
        // beat outside the buffer is dropped
        add_load(4'd3, eflash_drv_pkg::beat_data_t'($urandom));
        // READ with buf_read high keeps row data at zero while the buffer holds data
        row = rand_row();
        col = rand_col();
        for (int p = 12; p >= 0; p--) begin
            add_cmd(make_cmd(1'b1, eflash_drv_pkg::OP_READ, eflash_drv_pkg::phase_t'(p),
                             row, col), 1'b1, 1'b1);
        end
        row = rand_row();
        col = rand_col();
        for (int p = 12; p >= 0; p--) begin
            add_cmd(make_cmd(1'b1, eflash_drv_pkg::OP_RBR, eflash_drv_pkg::phase_t'(p),
                             row, col), 1'b1, 1'b1);
        end
        add_cmd(make_cmd(1'b1, eflash_drv_pkg::OP_RBR, 4'd5, row, col), 1'b0, 1'b1);
        idle_ops[0] = eflash_drv_pkg::OP_ERASE;
        idle_ops[1] = eflash_drv_pkg::OP_PARALLEL;
        idle_ops[2] = eflash_drv_pkg::OP_LOAD;
        idle_ops[3] = eflash_drv_pkg::pim_op_e'(3'b000);
        for (int n = 0; n < 4; n++) begin
            add_cmd(make_cmd(1'b1, eflash_drv_pkg::OP_ERASE, 4'd0, rand_row(), rand_col()),
                    1'b0, 1'b1);
            add_cmd(make_cmd(n != 0, idle_ops[n], 4'd2, rand_row(), rand_col()), 1'b1, 1'b1);
        end
    endtask

    task automatic drive_entry(input entry_t e);
        cmd = e.cmd;
        buf_read = e.buf_read;
        load_valid = e.load_valid;
        load_beat = e.load_beat;
        load_data = e.load_data;
    endtask

    task automatic wait_fall(output logic ok);
        logic prev;
        int unsigned polls;
        ok = 1'b0;
        prev = clk;
        polls = 0;
        while (!ok && polls < EDGE_POLLS) begin
            #(POLL_NS);
            polls++;
            if (prev === 1'b1 && clk === 1'b0) begin
                ok = 1'b1;
            end
            prev = clk;
        end
        if (!ok) begin
            $display("timeout: no falling clock edge seen within %0d polls", EDGE_POLLS);
            n_errors++;
        end
    endtask

    task automatic check_outputs(input entry_t e, input string where);
        n_checks++;
        assert (wl === e.exp_wl) else begin
            $display("** Error: wl_o at %s: got %h, expected %h", where, wl, e.exp_wl);
            n_errors++;
        end
        assert (bl === e.exp_bl) else begin
            $display("** Error: bl_o at %s: got %h, expected %h", where, bl, e.exp_bl);
            n_errors++;
        end
        assert (!e.check_rows || row_data === e.exp_rows) else begin
            $display("** Error: row_data_o at %s: got %h, expected %h",
                     where, row_data, e.exp_rows);
            n_errors++;
        end
    endtask

    initial begin
        logic        ok;
        int unsigned polls;
        entry_t      rst_e;
        void'($urandom(32'h34b7));
        cmd = '0;
        load_valid = 1'b0;
        load_beat = '0;
        load_data = '0;
        buf_read = 1'b0;
        shadow = '0;
        n_errors = 0;
        n_checks = 0;
        ok = 1'b1;
        build_table();
        polls = 0;
        while (rst_n !== 1'b1 && polls < RESET_POLLS) begin
            #(POLL_NS);
            polls++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            n_errors++;
            ok = 1'b0;
        end
        if (ok) begin
            // no rising edge since release, so the flops still hold their reset values
            rst_e.exp_wl.mode = eflash_drv_pkg::HV_ERASE;
            rst_e.exp_wl.wl_sel = '0;
            rst_e.exp_wl.vpass_en = '1;
            rst_e.exp_bl = '0;
            rst_e.exp_rows = '0;
            rst_e.check_rows = 1'b1;
            check_outputs(rst_e, "reset");
            wait_fall(ok);
        end
        for (int i = 0; ok && i < stim_q.size(); i++) begin
            drive_entry(stim_q[i]);
            wait_fall(ok);
            if (ok) begin
                check_outputs(stim_q[i], $sformatf("entry %0d", i));
            end
        end
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
rtl/eflash_drv_pkg.sv
rtl/wordline_decoder.sv
rtl/bitline_sequencer.sv
rtl/input_row_buffer.sv
rtl/eflash_row_driver.sv
dv/tb_clock_gen.sv
dv/eflash_row_driver_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= eflash_row_driver_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Done: no errors

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
